// File: design/byte_packer.sv
// Leftover bytes under one word stay held; controller must keep fill within ACC_BYTES
`timescale 1ns/1ps

module byte_packer
    import ff_checker_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         load,
    input  group_t       group,
    input  group_count_t group_count,
    input  logic         emit,
    output level_t       level,
    output word_t        word_out,
    output logic         word_out_valid
);

    byte_t  acc_q    [ACC_BYTES];   // Index 0 is the oldest byte
    byte_t  acc_next [ACC_BYTES];
    level_t level_next;
    word_t  top_word;

    always_comb begin
        for (int i = 0; i < WORD_BYTES; i++) begin
            top_word[(WORD_BYTES-1-i)*BYTE_W +: BYTE_W] = acc_q[i];
        end
    end

    always_comb begin
        int base;
        int fill;
        base = int'(level);
        for (int k = 0; k < ACC_BYTES; k++) begin
            acc_next[k] = acc_q[k];
        end
        if (emit) begin
            // Shift remaining bytes up by one word
            for (int k = 0; k < ACC_BYTES - WORD_BYTES; k++) begin
                acc_next[k] = acc_q[k + WORD_BYTES];
            end
            for (int k = ACC_BYTES - WORD_BYTES; k < ACC_BYTES; k++) begin
                acc_next[k] = '0;
            end
            base = base - WORD_BYTES;
        end
        fill = base;
        if (load) begin
            for (int j = 0; j < GROUP_BYTES; j++) begin
                if (j < int'(group_count) && base + j < ACC_BYTES) begin
                    acc_next[base + j] = group[(GROUP_BYTES-1-j)*BYTE_W +: BYTE_W];
                end
            end
            fill = base + int'(group_count);   // Append after what is left
        end
        level_next = level_t'(fill);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            level          <= '0;
            word_out_valid <= 1'b0;
        end else begin
            level          <= level_next;
            word_out_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < ACC_BYTES; k++) begin
            acc_q[k] <= acc_next[k];
        end
        if (emit) word_out <= top_word;
    end

    a_level_bound: assert property (@(posedge clk) disable iff (rst)
        level <= level_t'(ACC_BYTES))
        else $error("byte_packer level above capacity");

    // Controller must only emit once a whole word is held
    a_emit_full_word: assert property (@(posedge clk) disable iff (rst)
        emit |-> level >= level_t'(WORD_BYTES))
        else $error("byte_packer emit below one word");

endmodule

// File: design/byte_stuffer.sv
// Fixed 2-cycle latency, no stall; accepts at most one word per cycle, MSB byte first
`timescale 1ns/1ps

module byte_stuffer
    import ff_checker_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  word_t        word_in,
    input  logic         word_in_valid,
    output group_t       group,
    output group_count_t group_count,
    output logic         group_valid
);

    word_t                 word_q;
    logic [WORD_BYTES-1:0] flag_q;      // Bit i set when byte i is a marker
    logic                  valid_q;
    group_t                group_next;
    group_count_t          count_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q     <= 1'b0;
            group_valid <= 1'b0;
        end else begin
            valid_q     <= word_in_valid;
            group_valid <= valid_q;
        end
    end

    // Stage 1 flags marker bytes
    always_ff @(posedge clk) begin
        if (word_in_valid) begin
            word_q <= word_in;
            for (int i = 0; i < WORD_BYTES; i++) begin
                flag_q[i] <= word_in[(WORD_BYTES-1-i)*BYTE_W +: BYTE_W] == MARKER_BYTE;
            end
        end
    end

    // Expand into a left-aligned group
    always_comb begin
        int    pos;
        byte_t cur;
        pos        = 0;
        group_next = '0;
        for (int i = 0; i < WORD_BYTES; i++) begin
            cur = word_q[(WORD_BYTES-1-i)*BYTE_W +: BYTE_W];
            group_next[(GROUP_BYTES-1-pos)*BYTE_W +: BYTE_W] = cur;
            pos = pos + 1;
            if (flag_q[i]) begin
                group_next[(GROUP_BYTES-1-pos)*BYTE_W +: BYTE_W] = STUFF_BYTE;
                pos = pos + 1;
            end
        end
        count_next = group_count_t'(pos);   // 4 plus number of markers
    end

    // Stage 2 output register
    always_ff @(posedge clk) begin
        if (valid_q) begin
            group       <= group_next;
            group_count <= count_next;
        end
    end

endmodule

// File: design/ff_checker.sv
// Marker stuffing top; no end-of-stream flush, so a trailing partial word is never emitted
`timescale 1ns/1ps

module ff_checker
    import ff_checker_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t word_in,
    input  logic  word_in_valid,
    output word_t word_out,
    output logic  word_out_valid
);

    group_t       group;
    group_count_t group_count;
    logic         group_valid;
    group_t       rd_group;
    group_count_t rd_count;
    logic         rd_valid;
    logic         fifo_rd;
    logic         fifo_empty;
    logic         load;
    logic         emit;
    level_t       level;

    byte_stuffer i_stuffer (
        .clk          (clk),
        .rst          (rst),
        .word_in      (word_in),
        .word_in_valid(word_in_valid),
        .group        (group),
        .group_count  (group_count),
        .group_valid  (group_valid)
    );

    // Decouples stuffer bursts from packer drain
    stuff_fifo i_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (group_valid),
        .wr_group(group),
        .wr_count(group_count),
        .rd_en   (fifo_rd),
        .rd_group(rd_group),
        .rd_count(rd_count),
        .rd_valid(rd_valid),
        .empty   (fifo_empty)
    );

    pack_ctrl i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .fifo_empty(fifo_empty),
        .rd_valid  (rd_valid),
        .level     (level),
        .fifo_rd   (fifo_rd),
        .load      (load),
        .emit      (emit)
    );

    byte_packer i_packer (
        .clk           (clk),
        .rst           (rst),
        .load          (load),
        .group         (rd_group),
        .group_count   (rd_count),
        .emit          (emit),
        .level         (level),
        .word_out      (word_out),
        .word_out_valid(word_out_valid)
    );

endmodule

// File: design/ff_checker_pkg.sv
// Sizes assume byte-aligned 32-bit words; FIFO depth relies on input strobes at least 5 cycles apart
package ff_checker_pkg;

    localparam int BYTE_W      = 8;
    localparam int WORD_BYTES  = 4;
    localparam int GROUP_BYTES = 8;   // Worst case, every byte followed by a stuff byte
    localparam int ACC_BYTES   = 12;
    localparam int FIFO_DEPTH  = 16;

    typedef logic [BYTE_W-1:0]             byte_t;
    typedef logic [WORD_BYTES*BYTE_W-1:0]  word_t;
    typedef logic [GROUP_BYTES*BYTE_W-1:0] group_t;   // Left-aligned, first byte on top
    typedef logic [3:0]                    group_count_t;
    typedef logic [3:0]                    level_t;

    // JPEG marker escape
    localparam byte_t MARKER_BYTE = 8'hFF;
    localparam byte_t STUFF_BYTE  = 8'h00;

    typedef enum logic {
        IDLE,
        WAIT
    } pack_state_t;

endpackage

// File: design/pack_ctrl.sv
// One FIFO read in flight at a time; reads only while packer holds under one word
`timescale 1ns/1ps

module pack_ctrl
    import ff_checker_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   fifo_empty,
    input  logic   rd_valid,
    input  level_t level,
    output logic   fifo_rd,
    output logic   load,
    output logic   emit
);

    pack_state_t state_q;
    pack_state_t state_next;
    logic        room;

    // Below one word, so a full group still fits
    assign room    = level < level_t'(WORD_BYTES);
    assign fifo_rd = (state_q == IDLE) && !fifo_empty && room;
    assign load    = rd_valid;
    assign emit    = level >= level_t'(WORD_BYTES);

    always_comb begin
        state_next = state_q;
        case (state_q)
            IDLE: if (fifo_rd) state_next = WAIT;
            WAIT: if (rd_valid) state_next = IDLE;   // Data lands this cycle
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_next;
        end
    end

    // FIFO answers only the read issued from IDLE
    a_rd_in_wait: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> state_q == WAIT)
        else $error("pack_ctrl got read data outside WAIT");

endmodule

// File: design/stuff_fifo.sv
// Read data one cycle after rd_en; caller must never write when full or read when empty
`timescale 1ns/1ps

module stuff_fifo
    import ff_checker_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         wr_en,
    input  group_t       wr_group,
    input  group_count_t wr_count,
    input  logic         rd_en,
    output group_t       rd_group,
    output group_count_t rd_count,
    output logic         rd_valid,
    output logic         empty
);

    group_t       group_mem [FIFO_DEPTH];
    group_count_t count_mem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;   // Wraps on power-of-two depth
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH):0]   occupancy;
    logic                          full;

    assign empty = occupancy == 0;
    assign full  = occupancy == FIFO_DEPTH;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            rd_valid  <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;   // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            group_mem[wr_ptr] <= wr_group;
            count_mem[wr_ptr] <= wr_count;
        end
        if (rd_en) begin
            rd_group <= group_mem[rd_ptr];
            rd_count <= count_mem[rd_ptr];
        end
    end

    // Input strobes spaced too closely would overrun the buffer
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
        else $error("stuff_fifo write while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
        else $error("stuff_fifo read while empty");

endmodule

// File: ff_checker.f
design/ff_checker_pkg.sv
design/byte_stuffer.sv
design/stuff_fifo.sv
design/pack_ctrl.sv
design/byte_packer.sv
design/ff_checker.sv
testbench/ff_checker_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the ff_checker testbench with Verilator; exit status is the result

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ff_checker_tb \
    --Mdir obj_dir \
    -o ff_checker_sim \
    -f ff_checker.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/ff_checker_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished successfully"
exit 0

// File: testbench/ff_checker_tb.sv
// Self-checking DUT test; input strobes kept at the 5-cycle minimum, trailing partial word never checked
`timescale 1ns/1ps

module ff_checker_tb
    import ff_checker_pkg::*;
;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 10;
    localparam int QUIET_CYCLES = 20;
    localparam int MIN_GAP      = 5;   // Cycles between input strobes
    localparam int N_PLAIN      = 8;
    localparam int N_ALL_FF     = 3;
    localparam int N_CORNER     = 4;
    localparam int N_RANDOM     = 40;
    localparam int N_BURST      = 16;
    localparam int N_WORDS      = N_PLAIN + N_ALL_FF + N_CORNER + N_RANDOM + N_BURST;

    logic  clk;
    logic  rst;
    word_t word_in;
    logic  word_in_valid;
    word_t word_out;
    logic  word_out_valid;

    byte_t exp_q [$];       // Stuffed bytes not yet seen at the output
    int    total_bytes;
    int    out_count;

    ff_checker i_dut (
        .clk           (clk),
        .rst           (rst),
        .word_in       (word_in),
        .word_in_valid (word_in_valid),
        .word_out      (word_out),
        .word_out_valid(word_out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
            $display("test failed");
            $fatal(1, "Value check failed");
        end
    endtask

    // Each byte MSB first, a zero byte after every marker
    function automatic int stuff_ref(input word_t w, output byte_t bytes [GROUP_BYTES]);
        int    n;
        byte_t b;
        n = 0;
        for (int i = 0; i < GROUP_BYTES; i++) begin
            bytes[i] = 8'h00;
        end
        for (int i = WORD_BYTES - 1; i >= 0; i--) begin
            b = w[i*BYTE_W +: BYTE_W];
            bytes[n] = b;
            n++;
            if (b == 8'hFF) begin
                bytes[n] = 8'h00;
                n++;
            end
        end
        return n;
    endfunction

    // One in four bytes is a marker when allowed
    function automatic word_t random_word(input bit allow_ff);
        word_t w;
        for (int i = 0; i < WORD_BYTES; i++) begin
            if (allow_ff && $urandom_range(0, 3) == 0) begin
                w[i*BYTE_W +: BYTE_W] = 8'hFF;
            end else begin
                w[i*BYTE_W +: BYTE_W] = byte_t'($urandom_range(0, 254));
            end
        end
        return w;
    endfunction

    task automatic send_word(input word_t w);
        byte_t bytes [GROUP_BYTES];
        int    n;
        @(posedge clk);
        word_in       <= w;
        word_in_valid <= 1'b1;
        n = stuff_ref(w, bytes);
        for (int i = 0; i < n; i++) begin
            exp_q.push_back(bytes[i]);
        end
        total_bytes += n;
        @(posedge clk);
        word_in_valid <= 1'b0;
        repeat (MIN_GAP - 2) @(posedge clk);   // Keeps strobes MIN_GAP apart
    endtask

    always @(negedge clk) begin
        word_t expected;
        if (word_out_valid === 1'b1) begin
            if (exp_q.size() < WORD_BYTES) begin
                $display("Output word 0x%h arrived with fewer than four bytes expected",
                         word_out);
                $display("test failed");
                $fatal(1, "Unexpected output word");
            end else begin
                expected = '0;
                for (int i = 0; i < WORD_BYTES; i++) begin
                    expected = {expected[23:0], exp_q.pop_front()};
                end
                check_value("word_out", expected, word_out);
                out_count++;
            end
        end
    end

    initial begin
        #((N_WORDS * MIN_GAP + 200) * CLK_PERIOD);
        $display("Timeout: output stopped after %0d words", out_count);
        $display("test failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int quiet;
        void'($urandom(1));
        rst           = 1'b1;
        word_in       = '0;
        word_in_valid = 1'b0;
        total_bytes   = 0;
        out_count     = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // Nothing may leave before the first word goes in
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_value("word_out_valid", 32'h0, 32'(word_out_valid));
        end

        for (int i = 0; i < N_PLAIN; i++) send_word(random_word(1'b0));
        for (int i = 0; i < N_ALL_FF; i++) send_word(32'hFFFF_FFFF);

        send_word(32'hFF00_0000);   // Marker in first and last position
        send_word(32'h0000_00FF);
        send_word(32'hFFFF_0012);
        send_word(32'h00FF_00FF);

        for (int i = 0; i < N_RANDOM; i++) send_word(random_word(1'b1));
        for (int i = 0; i < N_BURST; i++) send_word(random_word(1'b1));

        // Drain until the output has been idle for a while
        quiet = 0;
        while (quiet < QUIET_CYCLES) begin
            @(negedge clk);
            if (word_out_valid === 1'b1) begin
                quiet = 0;
            end else begin
                quiet = quiet + 1;
            end
        end

        check_value("out_count", 32'(total_bytes / WORD_BYTES), 32'(out_count));
        $display("test passed");
        $finish;
    end

endmodule
